/* wb_subsystem.f */
+incdir+verif
hdl/wb_pkg.sv
hdl/stream_flow.sv
hdl/load_align.sv
hdl/wb_arbiter.sv
hdl/reg_file.sv
hdl/wb_subsystem.sv
verif/wb_subsystem_tb.sv

/* Bender.yml */
package:
  name: wb_subsystem

sources:
  - files:
      - hdl/wb_pkg.sv
      - hdl/stream_flow.sv
      - hdl/load_align.sv
      - hdl/wb_arbiter.sv
      - hdl/reg_file.sv
      - hdl/wb_subsystem.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/wb_subsystem_tb.sv

/* verif/wb_vectors.svh */
// one row per step, columns are
// name, offered sources {execute, load, system}, command lag, data lag, wb_ready low cycles,
// dest (execute writes dest, the load dest+1, system dest+2), load kind, byte offset,
// raw memory word, register read back on rs1

typedef struct packed {
    logic [8*12-1:0] name;
    logic [2:0]      offer;
    logic [1:0]      cmd_lag;
    logic [1:0]      data_lag;
    logic [2:0]      stall;
    reg_addr_t       dest;
    load_op_t        op;
    byte_offset_t    offset;
    word_t           mem_word;
    reg_addr_t       read_reg;
} step_t;

localparam int num_steps = 20;

// lanes of 8a7ff501 and 7ff080c3 give both signs for bytes and halfwords
localparam step_t steps [num_steps] = '{
    '{"exe_single", 3'b100, 2'd0, 2'd0, 3'd0, 5'd5, load_lw, 2'd0, 32'h00000000, 5'd5},
    '{"lb_off0", 3'b010, 2'd0, 2'd0, 3'd0, 5'd7, load_lb, 2'd0, 32'h8a7ff501, 5'd8},
    '{"lb_off1", 3'b010, 2'd0, 2'd0, 3'd0, 5'd8, load_lb, 2'd1, 32'h8a7ff501, 5'd9},
    '{"lb_off2", 3'b010, 2'd0, 2'd0, 3'd0, 5'd9, load_lb, 2'd2, 32'h8a7ff501, 5'd10},
    '{"lb_off3", 3'b010, 2'd0, 2'd0, 3'd0, 5'd10, load_lb, 2'd3, 32'h8a7ff501, 5'd11},
    '{"lbu_off0", 3'b010, 2'd0, 2'd0, 3'd0, 5'd11, load_lbu, 2'd0, 32'h8a7ff501, 5'd12},
    '{"lbu_off1", 3'b010, 2'd0, 2'd0, 3'd0, 5'd12, load_lbu, 2'd1, 32'h8a7ff501, 5'd13},
    '{"lbu_off2", 3'b010, 2'd0, 2'd0, 3'd0, 5'd13, load_lbu, 2'd2, 32'h8a7ff501, 5'd14},
    '{"lbu_off3", 3'b010, 2'd0, 2'd0, 3'd0, 5'd14, load_lbu, 2'd3, 32'h8a7ff501, 5'd15},
    '{"lh_off0", 3'b010, 2'd0, 2'd0, 3'd0, 5'd15, load_lh, 2'd0, 32'h8a7ff501, 5'd16},
    '{"lh_off2", 3'b010, 2'd0, 2'd0, 3'd0, 5'd16, load_lh, 2'd2, 32'h7ff080c3, 5'd17},
    '{"lhu_off0", 3'b010, 2'd0, 2'd0, 3'd0, 5'd17, load_lhu, 2'd0, 32'h7ff080c3, 5'd18},
    '{"lhu_off2", 3'b010, 2'd0, 2'd0, 3'd0, 5'd18, load_lhu, 2'd2, 32'h8a7ff501, 5'd19},
    '{"lw_off0", 3'b010, 2'd0, 2'd0, 3'd0, 5'd19, load_lw, 2'd0, 32'h8a7ff501, 5'd20},
    '{"rr_first", 3'b111, 2'd0, 2'd0, 3'd0, 5'd10, load_lw, 2'd0, 32'h13572468, 5'd12},
    '{"rr_second", 3'b111, 2'd0, 2'd0, 3'd0, 5'd20, load_lbu, 2'd3, 32'h8a7ff501, 5'd21},
    '{"wait_data", 3'b111, 2'd0, 2'd3, 3'd0, 5'd24, load_lh, 2'd2, 32'h7ff080c3, 5'd25},
    '{"wait_cmd", 3'b111, 2'd3, 2'd0, 3'd0, 5'd27, load_lhu, 2'd0, 32'h8a7ff501, 5'd28},
    '{"stall_held", 3'b111, 2'd0, 2'd0, 3'd5, 5'd3, load_lb, 2'd2, 32'h7ff080c3, 5'd4},
    '{"x0_write", 3'b100, 2'd0, 2'd0, 3'd0, 5'd0, load_lw, 2'd0, 32'h00000000, 5'd0}
};

/* verif/wb_subsystem_tb.sv */
`timescale 1ns/1ns

module wb_subsystem_tb;

    import wb_pkg::*;

    `include "wb_vectors.svh"

    // a step settles well inside 40 cycles
    localparam int cycle_limit = num_steps * 40 + 100;

    logic clk, rst;
    logic execute_valid, execute_ready, system_valid, system_ready;
    logic mem_cmd_valid, mem_cmd_ready, mem_data_valid, mem_data_ready;
    logic wb_valid, wb_ready;
    wb_operation_t execute_payload, system_payload, wb_payload;
    mem_operation_t mem_cmd_payload;
    word_t mem_data, rs1_data, rs2_data;
    reg_addr_t rs1_addr, rs2_addr;

    // scoreboard state
    wb_source_t model_pointer;
    wb_operation_t expected [$];
    word_t shadow [reg_count];
    int cycles = 0;

    wb_subsystem i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            stop_run($sformatf("timeout: run still busy after %0d cycles", cycle_limit));
        end
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_payload(input string name, input wb_operation_t exp,
                                 input wb_operation_t act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s: expected x%0d=%h, actual x%0d=%h",
                               name, exp.dest, exp.value, act.dest, act.value));
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // wb_valid followed by the execute, command, data and system readies
    task automatic check_flags(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Fail %s flags: expected %b, actual %b", name, exp, act));
        end
    endtask

    // pick the lane at the offset, then sign- or zero-extend
    function automatic word_t align_expect(input word_t raw, input load_op_t op,
                                           input byte_offset_t offset);
        logic [7:0] lane8;
        logic [15:0] lane16;
        lane8 = raw[8*offset +: 8];
        lane16 = raw[16*offset[1] +: 16];
        case (op)
            load_lb: return {{24{lane8[7]}}, lane8};
            load_lbu: return {24'd0, lane8};
            load_lh: return {{16{lane16[15]}}, lane16};
            load_lhu: return {16'd0, lane16};
            default: return raw;
        endcase
    endfunction

    // drives one table row until its results are written back and read
    task automatic run_step(input step_t st);
        string name;
        wb_operation_t load_result;
        logic [2:0] left;
        logic [2:0] avail;
        logic [2:0] chosen;
        logic held;
        logic free;
        int cyc;
        int first;
        int idx;
        name = string'(st.name);
        execute_payload = '{dest: st.dest, value: $urandom()};
        mem_cmd_payload = '{dest: st.dest + 5'd1, op: st.op, offset: st.offset};
        system_payload = '{dest: st.dest + 5'd2, value: $urandom()};
        mem_data = st.mem_word;
        rs1_addr = st.read_reg;
        // second port follows the load destination
        rs2_addr = st.dest + 5'd1;
        left = st.offer;
        cyc = 0;
        do begin
            execute_valid = left[2];
            mem_cmd_valid = left[1] && (cyc >= st.cmd_lag);
            mem_data_valid = left[1] && (cyc >= st.data_lag);
            system_valid = left[0];
            wb_ready = (cyc >= st.stall);
            @(negedge clk);
            held = (expected.size() != 0);
            if (held) check_payload(name, expected[0], wb_payload);
            check_word({name, " rs1"}, shadow[st.read_reg], rs1_data);
            check_word({name, " rs2"}, shadow[rs2_addr], rs2_data);
            // slot takes a new result when empty or draining
            free = !held || wb_ready;
            if (held && wb_ready) begin
                if (expected[0].dest != '0) shadow[expected[0].dest] = expected[0].value;
                void'(expected.pop_front());
            end
            // source bits run execute, load, system from bit 2 down
            avail = {execute_valid, mem_cmd_valid && mem_data_valid, system_valid};
            chosen = 3'b000;
            first = 2 - int'(model_pointer);
            for (int k = 0; k < 3; k++) begin
                idx = (first - k + 3) % 3;
                if (free && chosen == 3'b000 && avail[idx]) chosen[idx] = 1'b1;
            end
            check_flags(name, {held, chosen[2], chosen[1], chosen[1], chosen[0]},
                        {wb_valid, execute_ready, mem_cmd_ready, mem_data_ready, system_ready});
            load_result = '{dest: mem_cmd_payload.dest,
                            value: align_expect(mem_data, st.op, st.offset)};
            if (chosen[2]) expected.push_back(execute_payload);
            if (chosen[1]) expected.push_back(load_result);
            if (chosen[0]) expected.push_back(system_payload);
            if (chosen != 3'b000) begin
                model_pointer = (model_pointer == source_system) ? source_execute
                                                                 : wb_source_t'(model_pointer + 1);
                left = left & ~chosen;
            end
            @(posedge clk);
            #2;
            cyc++;
        end while (left != 3'b000 || expected.size() != 0 || held);
    endtask

    initial begin
        {execute_valid, mem_cmd_valid, mem_data_valid, system_valid, wb_ready} = '0;
        {execute_payload, system_payload, mem_cmd_payload, mem_data} = '0;
        {rs1_addr, rs2_addr} = '0;
        rst = 1'b1;
        void'($urandom(32'h9f87));
        model_pointer = source_execute;
        foreach (shadow[i]) shadow[i] = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int s = 0; s < num_steps; s++) begin
            run_step(steps[s]);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* hdl/wb_subsystem.sv */
`timescale 1ns/1ns

module wb_subsystem (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   execute_valid,
    output logic                   execute_ready,
    input  wb_pkg::wb_operation_t  execute_payload,

    input  logic                   system_valid,
    output logic                   system_ready,
    input  wb_pkg::wb_operation_t  system_payload,

    input  logic                   mem_cmd_valid,
    output logic                   mem_cmd_ready,
    input  wb_pkg::mem_operation_t mem_cmd_payload,

    input  logic                   mem_data_valid,
    output logic                   mem_data_ready,
    input  wb_pkg::word_t          mem_data,

    output logic                   wb_valid,
    input  logic                   wb_ready,
    output wb_pkg::wb_operation_t  wb_payload,

    input  wb_pkg::reg_addr_t      rs1_addr,
    input  wb_pkg::reg_addr_t      rs2_addr,
    output wb_pkg::word_t          rs1_data,
    output wb_pkg::word_t          rs2_data
);

    logic write_valid;

    // commit on the output transfer
    assign write_valid = wb_valid && wb_ready;

    wb_arbiter i_arbiter (
        .clk            (clk),
        .rst            (rst),
        .execute_valid  (execute_valid),
        .execute_ready  (execute_ready),
        .execute_payload(execute_payload),
        .mem_cmd_valid  (mem_cmd_valid),
        .mem_cmd_ready  (mem_cmd_ready),
        .mem_cmd_payload(mem_cmd_payload),
        .mem_data_valid (mem_data_valid),
        .mem_data_ready (mem_data_ready),
        .mem_data       (mem_data),
        .system_valid   (system_valid),
        .system_ready   (system_ready),
        .system_payload (system_payload),
        .wb_valid       (wb_valid),
        .wb_ready       (wb_ready),
        .wb_payload     (wb_payload)
    );

    reg_file i_reg_file (
        .clk          (clk),
        .rst          (rst),
        .write_valid  (write_valid),
        .write_payload(wb_payload),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data)
    );

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  write_valid,
    input  wb_pkg::wb_operation_t write_payload,

    input  wb_pkg::reg_addr_t     rs1_addr,
    input  wb_pkg::reg_addr_t     rs2_addr,
    output wb_pkg::word_t         rs1_data,
    output wb_pkg::word_t         rs2_data
);

    import wb_pkg::*;

    word_t regs [reg_count];

    // x0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (write_valid && (write_payload.dest != '0)) begin
            regs[write_payload.dest] <= write_payload.value;
        end
    end

    // no bypass, a write shows up on the next cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* hdl/wb_arbiter.sv */
`timescale 1ns/1ns

module wb_arbiter (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   execute_valid,
    output logic                   execute_ready,
    input  wb_pkg::wb_operation_t  execute_payload,

    input  logic                   mem_cmd_valid,
    output logic                   mem_cmd_ready,
    input  wb_pkg::mem_operation_t mem_cmd_payload,

    input  logic                   mem_data_valid,
    output logic                   mem_data_ready,
    input  wb_pkg::word_t          mem_data,

    input  logic                   system_valid,
    output logic                   system_ready,
    input  wb_pkg::wb_operation_t  system_payload,

    output logic                   wb_valid,
    input  logic                   wb_ready,
    output wb_pkg::wb_operation_t  wb_payload
);

    import wb_pkg::*;

    logic enable;
    logic mem_valid;
    logic consume_execute;
    logic consume_mem;
    logic consume_system;
    logic [3:0] ready_in;

    wb_source_t pointer;
    wb_source_t next_pointer;

    word_t load_value;
    wb_operation_t mem_result;
    wb_operation_t next_payload;

    // a load needs its command and its data word together
    assign mem_valid = mem_cmd_valid && mem_data_valid;

    // command and data share one consume bit so both readies rise together
    stream_flow #(
        .num_inputs (4),
        .num_outputs(1)
    ) i_flow (
        .clk      (clk),
        .rst      (rst),
        .valid_in ({execute_valid, mem_cmd_valid, mem_data_valid, system_valid}),
        .ready_in (ready_in),
        .consume  ({consume_execute, consume_mem, consume_mem, consume_system}),
        .valid_out(wb_valid),
        .ready_out(wb_ready),
        .produce  (1'b1),
        .enable   (enable)
    );

    assign execute_ready  = ready_in[3];
    assign mem_cmd_ready  = ready_in[2];
    assign mem_data_ready = ready_in[1];
    assign system_ready   = ready_in[0];

    load_align i_align (
        .data  (mem_data),
        .op    (mem_cmd_payload.op),
        .offset(mem_cmd_payload.offset),
        .value (load_value)
    );

    assign mem_result = '{dest: mem_cmd_payload.dest, value: load_value};

    // first valid source from the pointer wins
    // with nothing valid the pointer's own source stays chosen and enable stays low
    always_comb begin
        consume_execute = 1'b0;
        consume_mem = 1'b0;
        consume_system = 1'b0;
        case (pointer)
            source_execute: begin
                if (execute_valid) consume_execute = 1'b1;
                else if (mem_valid) consume_mem = 1'b1;
                else if (system_valid) consume_system = 1'b1;
                else consume_execute = 1'b1;
                next_pointer = source_mem;
            end
            source_mem: begin
                if (mem_valid) consume_mem = 1'b1;
                else if (system_valid) consume_system = 1'b1;
                else if (execute_valid) consume_execute = 1'b1;
                else consume_mem = 1'b1;
                next_pointer = source_system;
            end
            default: begin
                if (system_valid) consume_system = 1'b1;
                else if (execute_valid) consume_execute = 1'b1;
                else if (mem_valid) consume_mem = 1'b1;
                else consume_system = 1'b1;
                next_pointer = source_execute;
            end
        endcase
    end

    always_comb begin
        if (consume_execute) next_payload = execute_payload;
        else if (consume_mem) next_payload = mem_result;
        else next_payload = system_payload;
    end

    // pointer only moves when a transfer happens
    always_ff @(posedge clk) begin
        if (rst) begin
            pointer <= source_execute;
        end else if (enable) begin
            pointer <= next_pointer;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            wb_payload <= next_payload;
        end
    end

endmodule

/* hdl/load_align.sv */
`timescale 1ns/1ns

module load_align (
    input  wb_pkg::word_t        data,
    input  wb_pkg::load_op_t     op,
    input  wb_pkg::byte_offset_t offset,
    output wb_pkg::word_t        value
);

    import wb_pkg::*;

    word_t shifted;

    // bring the addressed byte lane down to bit 0
    assign shifted = data >> {offset, 3'b000};

    always_comb begin
        case (op)
            load_lb: begin
                value = {{(xlen - 8){shifted[7]}}, shifted[7:0]};
            end
            load_lh: begin
                value = {{(xlen - 16){shifted[15]}}, shifted[15:0]};
            end
            load_lbu: begin
                value = {{(xlen - 8){1'b0}}, shifted[7:0]};
            end
            load_lhu: begin
                value = {{(xlen - 16){1'b0}}, shifted[15:0]};
            end
            // lw and the unused codes pass the word through
            default: begin
                value = shifted;
            end
        endcase
    end

endmodule

/* hdl/stream_flow.sv */
`timescale 1ns/1ns

module stream_flow #(
    parameter int num_inputs  = 1,
    parameter int num_outputs = 1
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic [num_inputs-1:0]  valid_in,
    output logic [num_inputs-1:0]  ready_in,
    input  logic [num_inputs-1:0]  consume,

    output logic [num_outputs-1:0] valid_out,
    input  logic [num_outputs-1:0] ready_out,
    input  logic [num_outputs-1:0] produce,

    output logic                   enable
);

    logic inputs_ready;
    logic outputs_free;
    logic [num_outputs-1:0] valid_next;

    // every consumed input has to hold data
    assign inputs_ready = &(valid_in | ~consume);

    // produced slots must be empty or drain this cycle
    assign outputs_free = &(~valid_out | ready_out | ~produce);

    assign enable = inputs_ready && outputs_free;

    // only the consumed inputs see ready, and only when the stage fires
    assign ready_in = enable ? consume : '0;

    // new data sets the flag, a drain without refill clears it
    assign valid_next = ({num_outputs{enable}} & produce) | (valid_out & ~ready_out);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out <= '0;
        end else begin
            valid_out <= valid_next;
        end
    end

endmodule

/* hdl/wb_pkg.sv */
package wb_pkg;

    // core data width
    localparam int xlen = 32;

    // architectural register count and index width
    localparam int reg_count = 32;
    localparam int reg_addr_width = $clog2(reg_count);

    // load encoding width and byte position width
    localparam int load_op_width = 3;
    localparam int offset_width = 2;

    typedef logic [xlen-1:0] word_t;

    typedef logic [reg_addr_width-1:0] reg_addr_t;

    typedef logic [offset_width-1:0] byte_offset_t;

    // follows the funct3 field of the load instructions
    typedef enum logic [load_op_width-1:0] {
        load_lb  = 3'b000,
        load_lh  = 3'b001,
        load_lw  = 3'b010,
        load_lbu = 3'b100,
        load_lhu = 3'b101
    } load_op_t;

    // one result headed for the register file
    typedef struct packed {
        reg_addr_t dest;
        word_t     value;
    } wb_operation_t;

    // load command issued ahead of the memory word
    typedef struct packed {
        reg_addr_t    dest;
        load_op_t     op;
        byte_offset_t offset;
    } mem_operation_t;

    // round-robin pointer over the result producers
    typedef enum logic [1:0] {
        source_execute = 2'd0,
        source_mem     = 2'd1,
        source_system  = 2'd2
    } wb_source_t;

endpackage
